/* source/spi_bridge_pkg.sv */
// Frame format and sizing shared by the RTL and the testbench
// Frames are two bytes, a command byte then a data byte
package spi_bridge_pkg;

    // SPI byte width
    localparam int BYTE_W = 8;

    // Register address field in the command byte
    localparam int REG_ADDR_W = 4;
    localparam int REG_COUNT = 2 ** REG_ADDR_W;

    // Command byte bit 7 set means write
    localparam int WRITE_BIT = 7;

    // Returned on miso during every command byte
    localparam logic [BYTE_W-1:0] SYNC_BYTE = 8'hA5;

    // Read-only register counting accepted writes
    localparam int COUNT_REG_ADDR = 15;

    // Byte FIFO entries
    // Must be a power of two
    localparam int FIFO_DEPTH = 4;

endpackage

/* source/byte_stream_if.sv */
`timescale 1ns/100ps
// Byte stream with a frame start mark
// A byte moves on an ext_clk edge with valid and ready both high
interface byte_stream_if;
    import spi_bridge_pkg::*;

    // Payload byte
    logic [BYTE_W-1:0] data;
    // First byte after slave select was idle
    logic first;
    logic valid;
    logic ready;

    // Producer side
    modport source (
        output data,
        output first,
        output valid,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data,
        input  first,
        input  valid,
        output ready
    );

endinterface

/* source/spi_slave.sv */
`timescale 1ns/100ps
// SPI mode 0 only; sclk must be far slower than ext_clk (8x or more)
// Bytes are not held, so rx.valid is a one-cycle pulse and ready is ignored
module spi_slave (
    input  logic                              ext_clk,
    input  logic                              rst,
    input  logic                              sclk,
    input  logic                              mosi,
    input  logic                              ss,
    input  logic [spi_bridge_pkg::BYTE_W-1:0] send_data,
    output logic                              miso,
    output logic                              send_ready,
    byte_stream_if.source                     rx
);
    import spi_bridge_pkg::*;

    // sclk domain
    logic [$clog2(BYTE_W)-1:0] bit_cnt;
    logic [BYTE_W-1:0]         recv_buf;
    logic [BYTE_W-1:0]         send_buf;
    logic                      tx_done;
    logic                      bit_rst;

    // ext_clk domain
    logic done_sync1;
    logic done_sync2;
    logic done_seen;
    logic byte_aborted;
    logic ss_idle_sync1;
    logic ss_idle_sync2;
    logic first_pending;
    logic byte_done;

    // Counter clears on reset or once ss idle is confirmed
    assign bit_rst = rst || ss_idle_sync2;
    assign tx_done = (bit_cnt == '0);

    // MSB first, next bit after every falling sclk edge
    assign miso = !ss && send_buf[BYTE_W - 1 - bit_cnt];

    // Whole byte seen by both sync stages, not yet reported
    assign byte_done = done_sync1 && done_sync2 && tx_done && !done_seen && !byte_aborted;

    // Sample mosi on rising sclk
    always_ff @(posedge sclk) begin
        if (!ss) begin
            recv_buf <= {recv_buf[BYTE_W-2:0], mosi};
        end
    end

    // Bit position, advanced on falling sclk
    // A rise of ss mid-byte throws the partial byte away
    always_ff @(negedge sclk, posedge bit_rst) begin
        if (bit_rst) begin
            bit_cnt <= '0;
        end else if (!ss) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Reply byte follows send_data, sampled away from the rising ext_clk edge
    always_ff @(negedge ext_clk) begin
        send_buf <= send_data;
    end

    // Two-stage sync of the byte-complete flag
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            done_sync1   <= 1'b1;
            done_sync2   <= 1'b1;
            done_seen    <= 1'b1;
            byte_aborted <= 1'b0;
        end else begin
            done_sync1 <= tx_done;
            done_sync2 <= done_sync1 && tx_done;
            done_seen  <= done_sync1 && done_sync2 && tx_done;
            // Counter went to zero by ss idle rather than by the eighth edge
            if (done_sync1 && !done_sync2) begin
                byte_aborted <= ss_idle_sync2;
            end
        end
    end

    // ss idle filter
    // Any disagreement keeps the previous state
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            ss_idle_sync1 <= 1'b1;
            ss_idle_sync2 <= 1'b1;
        end else begin
            ss_idle_sync1 <= ss;
            if (ss == ss_idle_sync1) begin
                ss_idle_sync2 <= ss_idle_sync1;
            end
        end
    end

    // Frame start mark for the next byte
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            first_pending <= 1'b1;
        end else if (ss_idle_sync2) begin
            first_pending <= 1'b1;
        end else if (byte_done) begin
            first_pending <= 1'b0;
        end
    end

    // Output strobes
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            rx.valid   <= 1'b0;
            rx.first   <= 1'b0;
            send_ready <= 1'b0;
        end else begin
            rx.valid <= byte_done;
            if (byte_done) begin
                rx.first <= first_pending;
            end
            // New reply wanted after each byte and all through ss idle
            send_ready <= ss_idle_sync2 || rx.valid;
        end
    end

    // Received byte
    always_ff @(posedge ext_clk) begin
        if (byte_done) begin
            rx.data <= recv_buf;
        end
    end

endmodule

/* source/byte_fifo.sv */
`timescale 1ns/100ps
// Fall-through FIFO, head shows one cycle after a write into an empty FIFO
// Overflow is sticky until reset; the dropped byte is lost
module byte_fifo (
    input  logic        ext_clk,
    input  logic        rst,
    byte_stream_if.sink wr,
    byte_stream_if.source rd,
    output logic        overflow
);
    import spi_bridge_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Entry is {first, data}
    logic [BYTE_W:0] mem [FIFO_DEPTH];

    // Extra MSB tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           empty;
    logic           full;
    logic           push;
    logic           pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign push = wr.valid && !full;
    assign pop  = rd.valid && rd.ready;

    assign wr.ready = !full;

    // Head entry
    assign rd.valid             = !empty;
    assign {rd.first, rd.data}  = mem[rd_ptr[PTR_W-1:0]];

    // Storage
    always_ff @(posedge ext_clk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= {wr.first, wr.data};
        end
    end

    // Pointers
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Byte offered while full
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (wr.valid && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

/* source/reg_cmd_engine.sv */
`timescale 1ns/100ps
// Two-byte frames only; a lone command byte leaves its reply queued
// Register 15 is read-only and counts write frames modulo 256
module reg_cmd_engine (
    input  logic                              ext_clk,
    input  logic                              rst,
    input  logic                              send_ready,
    byte_stream_if.sink                       rx,
    output logic [spi_bridge_pkg::BYTE_W-1:0] reply_data
);
    import spi_bridge_pkg::*;

    // Register bank, last entry is the write counter
    logic [BYTE_W-1:0]     regs [REG_COUNT];

    // Frame tracker
    logic                  expect_data;
    logic                  cmd_write;
    logic [REG_ADDR_W-1:0] cmd_addr;

    logic                  take;
    logic                  is_cmd;
    logic [REG_ADDR_W-1:0] byte_addr;
    logic [BYTE_W-1:0]     byte_reply;
    logic [BYTE_W-1:0]     next_reply;
    logic [BYTE_W-1:0]     reply_sel;

    // Never stalls
    assign rx.ready = 1'b1;
    assign take     = rx.valid && rx.ready;

    // First byte after ss idle always opens a new frame
    assign is_cmd    = rx.first || !expect_data;
    assign byte_addr = rx.data[REG_ADDR_W-1:0];

    // Read command answers with the register, anything else with sync
    assign byte_reply = (is_cmd && !rx.data[WRITE_BIT]) ? regs[byte_addr] : SYNC_BYTE;

    // Byte arriving now wins over the stored choice
    assign reply_sel = take ? byte_reply : next_reply;

    // Command and data byte tracking
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            expect_data <= 1'b0;
            cmd_write   <= 1'b0;
            cmd_addr    <= '0;
        end else if (take) begin
            if (is_cmd) begin
                expect_data <= 1'b1;
                cmd_write   <= rx.data[WRITE_BIT];
                cmd_addr    <= byte_addr;
            end else begin
                expect_data <= 1'b0;
            end
        end
    end

    // Write lands at the edge that takes the data byte
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (take && !is_cmd && cmd_write) begin
            // Counter itself is not writable
            if (cmd_addr != COUNT_REG_ADDR) begin
                regs[cmd_addr] <= rx.data;
            end
            regs[COUNT_REG_ADDR] <= regs[COUNT_REG_ADDR] + 1'b1;
        end
    end

    // Reply for the next byte on miso
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            next_reply <= SYNC_BYTE;
        end else if (take) begin
            next_reply <= byte_reply;
        end
    end

    // Slave samples reply_data continuously
    // Only move it when the slave asks
    always_ff @(posedge ext_clk, posedge rst) begin
        if (rst) begin
            reply_data <= SYNC_BYTE;
        end else if (send_ready) begin
            reply_data <= reply_sel;
        end
    end

endmodule

/* source/spi_reg_bridge.sv */
`timescale 1ns/100ps
// SPI mode 0 bridge to sixteen 8-bit registers
// Master must leave 32 or more ext_clk cycles between bytes
module spi_reg_bridge (
    input  logic ext_clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic ss,
    output logic miso,
    output logic overflow
);
    import spi_bridge_pkg::*;

    // Reply handshake between engine and slave
    logic [BYTE_W-1:0] reply_data;
    logic              send_ready;

    // Received bytes toward the buffer
    byte_stream_if slave_to_fifo ();
    // Buffered bytes toward the decoder
    byte_stream_if fifo_to_engine ();

    // SPI pins to byte stream
    spi_slave u_slave (
        .ext_clk    (ext_clk),
        .rst        (rst),
        .sclk       (sclk),
        .mosi       (mosi),
        .ss         (ss),
        .send_data  (reply_data),
        .miso       (miso),
        .send_ready (send_ready),
        .rx         (slave_to_fifo.source)
    );

    byte_fifo u_fifo (
        .ext_clk  (ext_clk),
        .rst      (rst),
        .wr       (slave_to_fifo.sink),
        .rd       (fifo_to_engine.source),
        .overflow (overflow)
    );

    // Frame decode and register bank
    reg_cmd_engine u_engine (
        .ext_clk    (ext_clk),
        .rst        (rst),
        .send_ready (send_ready),
        .rx         (fifo_to_engine.sink),
        .reply_data (reply_data)
    );

endmodule

/* testbench/spi_bridge_checker.sv */
`timescale 1ns/100ps
// Samples the SPI pins on ext_clk, so sclk must be several times slower
// Only two-byte frames are compared, shorter ones count as discarded
module spi_bridge_checker (
    input  logic                              ext_clk,
    input  logic                              rst,
    input  logic                              sclk,
    input  logic                              mosi,
    input  logic                              miso,
    input  logic                              ss,
    input  logic                              overflow,
    input  logic [spi_bridge_pkg::BYTE_W-1:0] exp_reply,
    output int                                frame_count,
    output int                                drop_count,
    output int                                err_count
);
    import spi_bridge_pkg::*;

    // Expected register bank
    logic [BYTE_W-1:0]   model [REG_COUNT];
    // Command byte ends up in the upper half
    logic [2*BYTE_W-1:0] mosi_sh;
    logic [2*BYTE_W-1:0] miso_sh;
    int                  bit_cnt;
    logic                sclk_q;
    logic                ss_q;

    task automatic compare_byte(input string name, input logic [BYTE_W-1:0] want,
                                input logic [BYTE_W-1:0] got);
        if (got !== want) begin
            $display("ERR %s expected 0x%h got 0x%h", name, want, got);
            err_count++;
        end
    endtask

    task automatic check_frame();
        logic [BYTE_W-1:0]     cmd;
        logic [REG_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     want;
        int                    errs_before;
        cmd = mosi_sh[2*BYTE_W-1:BYTE_W];
        addr = cmd[REG_ADDR_W-1:0];
        errs_before = err_count;
        // Reads answer with the register in the second byte
        want = cmd[WRITE_BIT] ? SYNC_BYTE : model[addr];
        compare_byte("miso_byte", SYNC_BYTE, miso_sh[2*BYTE_W-1:BYTE_W]);
        compare_byte("miso_byte", want, miso_sh[BYTE_W-1:0]);
        // Table value too
        compare_byte("miso_byte", exp_reply, miso_sh[BYTE_W-1:0]);
        compare_byte("overflow", '0, BYTE_W'(overflow));
        if (cmd[WRITE_BIT]) begin
            if (addr != REG_ADDR_W'(COUNT_REG_ADDR)) begin
                model[addr] = mosi_sh[BYTE_W-1:0];
            end
            // Counted even when aimed at the counter
            model[COUNT_REG_ADDR] = model[COUNT_REG_ADDR] + 8'd1;
        end
        frame_count++;
        $display("frame %0d %s addr %0d data 0x%h reply 0x%h %s", frame_count,
                 cmd[WRITE_BIT] ? "write" : "read", addr, mosi_sh[BYTE_W-1:0],
                 miso_sh[BYTE_W-1:0], (err_count == errs_before) ? "ok" : "mismatch");
    endtask

    always @(posedge ext_clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                model[i] = '0;
            end
            bit_cnt = 0;
            sclk_q = 1'b0;
            ss_q = 1'b1;
            frame_count = 0;
            drop_count = 0;
            err_count = 0;
        end else begin
            // Master samples on rising sclk
            if (sclk && !sclk_q && !ss) begin
                mosi_sh = {mosi_sh[2*BYTE_W-2:0], mosi};
                miso_sh = {miso_sh[2*BYTE_W-2:0], miso};
                bit_cnt++;
            end
            if (ss && !ss_q) begin
                if (bit_cnt == 2 * BYTE_W) begin
                    check_frame();
                end else if (bit_cnt != 0) begin
                    drop_count++;
                    $display("frame discarded after %0d bits", bit_cnt);
                end
                bit_cnt = 0;
            end
            sclk_q = sclk;
            ss_q = ss;
        end
    end

endmodule

/* testbench/spi_bridge_assert.sv */
`timescale 1ns/100ps
// Bound to byte_fifo for the stream and overflow checks
// Bound to reg_cmd_engine for the reply check only, its stream input never stalls
module spi_bridge_assert #(
    // Stream and overflow checks when set, reply check otherwise
    parameter bit FIFO_SIDE = 1'b1
) (
    input logic                              ext_clk,
    input logic                              rst,
    input logic                              valid,
    input logic                              ready,
    input logic [spi_bridge_pkg::BYTE_W:0]   data,
    input logic                              sticky,
    input logic                              strobe,
    input logic [spi_bridge_pkg::BYTE_W-1:0] held
);

    if (FIFO_SIDE) begin : g_fifo
        // Stalled byte and first mark stay put
        hold_stalled: assert property (@(posedge ext_clk) disable iff (rst)
            valid && !ready |=> $stable(data))
            else $error("stream byte changed while stalled");

        // Sticky flag only clears by reset
        keep_sticky: assert property (@(posedge ext_clk) disable iff (rst)
            sticky |=> sticky)
            else $error("overflow fell without reset");
    end else begin : g_engine
        // Reply moves only after the slave asked for it
        reply_steady: assert property (@(posedge ext_clk) disable iff (rst)
            !strobe |=> $stable(held))
            else $error("reply_data changed without send_ready");
    end

endmodule

bind byte_fifo spi_bridge_assert #(.FIFO_SIDE(1'b1)) fifo_checks (
    .ext_clk (ext_clk),
    .rst     (rst),
    .valid   (rd.valid),
    .ready   (rd.ready),
    .data    ({rd.first, rd.data}),
    .sticky  (overflow),
    .strobe  (1'b0),
    .held    ('0)
);

bind reg_cmd_engine spi_bridge_assert #(.FIFO_SIDE(1'b0)) engine_checks (
    .ext_clk (ext_clk),
    .rst     (rst),
    .valid   (1'b0),
    .ready   (1'b1),
    .data    ('0),
    .sticky  (1'b0),
    .strobe  (send_ready),
    .held    (reply_data)
);

/* testbench/tb_spi_reg_bridge.sv */
`timescale 1ns/100ps
// Bit-banged SPI mode 0 master with an sclk half period of 4 ext_clk cycles
// Table rows are reads, writes or frames cut after 3 bits; write data from an LFSR
module tb_spi_reg_bridge;
    import spi_bridge_pkg::*;

    // Row kind sits in bits 7:6 of a script byte, address in bits 3:0
    localparam logic [1:0] KIND_RD    = 2'd0;
    localparam logic [1:0] KIND_WR    = 2'd1;
    localparam logic [1:0] KIND_ABORT = 2'd2;
    localparam int ROWS = 24;
    localparam int TIMEOUT_CYCLES = ROWS * 2 * 120 + 200;
    localparam logic [15:0] LFSR_SEED = 16'd56414;

    localparam logic [7:0] SCRIPT [ROWS] = '{
        8'h03, 8'h0F, 8'h43, 8'h47, 8'h03, 8'h07, 8'h0F, 8'h4F,
        8'h0F, 8'h87, 8'h07, 8'h40, 8'h41, 8'h4E, 8'h00, 8'h01,
        8'h0E, 8'h43, 8'h03, 8'h4A, 8'h0A, 8'h05, 8'h4F, 8'h0F
    };

    logic ext_clk;
    logic rst;
    logic sclk;
    logic mosi;
    logic ss;
    logic miso;
    logic overflow;

    // Stimulus table
    logic [1:0]        kind_tbl [ROWS];
    logic [BYTE_W-1:0] cmd_tbl [ROWS];
    logic [BYTE_W-1:0] data_tbl [ROWS];
    logic [BYTE_W-1:0] exp_tbl [ROWS];

    logic [BYTE_W-1:0] exp_reply;
    logic [15:0]       lfsr_state;
    int                cycle_cnt = 0;
    int                full_frames;
    int                frame_count;
    int                drop_count;
    int                err_count;

    spi_reg_bridge dut0 (.*);
    spi_bridge_checker chk0 (.*);

    always #10 ext_clk = ~ext_clk;

    // Run limit
    always @(posedge ext_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic draw_byte(output logic [BYTE_W-1:0] b);
        for (int i = 0; i < BYTE_W; i++) begin
            b[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Expands the script, expected replies follow the register rules
    task automatic build_table();
        logic [BYTE_W-1:0]     shadow [REG_COUNT];
        logic [BYTE_W-1:0]     writes;
        logic [REG_ADDR_W-1:0] a;
        logic [BYTE_W-1:0]     wd;
        for (int i = 0; i < REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        writes = '0;
        for (int r = 0; r < ROWS; r++) begin
            kind_tbl[r] = SCRIPT[r][7:6];
            a = SCRIPT[r][REG_ADDR_W-1:0];
            data_tbl[r] = '0;
            exp_tbl[r] = SYNC_BYTE;
            cmd_tbl[r] = (kind_tbl[r] == KIND_RD) ? {4'h0, a} : {4'h8, a};
            if (kind_tbl[r] == KIND_RD) begin
                // Register 15 holds the number of write frames
                exp_tbl[r] = (a == REG_ADDR_W'(COUNT_REG_ADDR)) ? writes : shadow[a];
            end else if (kind_tbl[r] == KIND_WR) begin
                draw_byte(wd);
                data_tbl[r] = wd;
                if (a != REG_ADDR_W'(COUNT_REG_ADDR)) begin
                    shadow[a] = wd;
                end
                writes = writes + 8'd1;
            end
        end
    endtask

    // MSB first, mosi changes while sclk is low
    task automatic send_byte(input logic [BYTE_W-1:0] tx, input int nbits);
        for (int i = BYTE_W - 1; i >= BYTE_W - nbits; i--) begin
            mosi = tx[i];
            repeat (4) @(negedge ext_clk);
            sclk = 1'b1;
            repeat (4) @(negedge ext_clk);
            sclk = 1'b0;
        end
    endtask

    task automatic run_frame(input int r);
        exp_reply = exp_tbl[r];
        ss = 1'b0;
        repeat (4) @(negedge ext_clk);
        if (kind_tbl[r] == KIND_ABORT) begin
            // ss rises after three bits of the command byte
            send_byte(cmd_tbl[r], 3);
        end else begin
            send_byte(cmd_tbl[r], BYTE_W);
            repeat (40) @(negedge ext_clk);
            send_byte(data_tbl[r], BYTE_W);
        end
        repeat (4) @(negedge ext_clk);
        ss = 1'b1;
        mosi = 1'b0;
        repeat (40) @(negedge ext_clk);
    endtask

    initial begin
        ext_clk = 1'b0;
        rst = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        ss = 1'b1;
        exp_reply = SYNC_BYTE;
        lfsr_state = LFSR_SEED;
        full_frames = 0;
        build_table();
        repeat (3) @(negedge ext_clk);
        rst = 1'b0;
        repeat (8) @(negedge ext_clk);
        for (int r = 0; r < ROWS; r++) begin
            if (kind_tbl[r] != KIND_ABORT) begin
                full_frames++;
            end
            run_frame(r);
        end
        repeat (8) @(negedge ext_clk);
        $display("frames checked %0d, discarded %0d, errors %0d",
                 frame_count, drop_count, err_count);
        if (frame_count != full_frames) begin
            $display("Checker saw %0d complete frames, %0d were sent", frame_count, full_frames);
        end
        if (err_count == 0 && frame_count == full_frames) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
source/spi_bridge_pkg.sv
source/byte_stream_if.sv
source/spi_slave.sv
source/byte_fifo.sv
source/reg_cmd_engine.sv
source/spi_reg_bridge.sv
testbench/spi_bridge_checker.sv
testbench/spi_bridge_assert.sv
testbench/tb_spi_reg_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the SPI register bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_spi_reg_bridge

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f sim.f -o sim_exe --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

./obj_dir/sim_exe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    echo "run_sim: testbench reported a failure, see $LOG"
    exit 1
fi

echo "run_sim: no failure reported"
exit 0
